//--- Bender.yml
package:
  name: apb_spi_master

sources:
  - files:
      - source/spi_pkg.sv
      - source/spi_fifo.sv
      - source/spi_apb_regs.sv
      - source/spi_xfer_fsm.sv
      - source/spi_sclk_timer.sv
      - source/spi_shift_reg.sv
      - source/spi_top.sv
  - target: test
    files:
      - testbench/tb_spi_top.sv

//--- filelist.f
source/spi_pkg.sv
source/spi_fifo.sv
source/spi_apb_regs.sv
source/spi_xfer_fsm.sv
source/spi_sclk_timer.sv
source/spi_shift_reg.sv
source/spi_top.sv
testbench/tb_spi_top.sv

//--- source/spi_apb_regs.sv
/*
 * SPI master APB register block
 * zero-wait slave: decodes accesses, holds CTRL and BAUD,
 * builds STAT, drives fifo push/pop strobes and pslverr
 */

`timescale 1ns/1ps

module spi_apb_regs
	import spi_pkg::*;
(
	input  logic                  pclk,
	input  logic                  preset_n,
	// apb slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [ADDR_W-1:0]     paddr,
	input  logic [DATA_W-1:0]     pwdata,
	input  logic [DATA_W/8-1:0]   pstrb,
	output logic [DATA_W-1:0]     prdata,
	output logic                  pready,
	output logic                  pslverr,
	// configuration
	output logic                  enable,
	output logic                  cpol,
	output logic                  cpha,
	output logic [GAP_W-1:0]      gap,
	output logic [BAUD_W-1:0]     baud,
	// fifo side
	output logic                  tx_push,
	output logic                  rx_pop,
	output logic                  fifo_clear,
	output logic [FRAME_BITS-1:0] tx_wdata,
	input  logic [FIFO_LVL_W-1:0] tx_level,
	input  logic [FIFO_LVL_W-1:0] rx_level,
	input  logic                  tx_full,
	input  logic                  tx_empty,
	input  logic                  rx_full,
	input  logic                  rx_empty,
	input  logic                  busy,
	input  logic [FRAME_BITS-1:0] rx_rdata
);

	apb_op_t           op;
	logic              acc_err;
	logic [DATA_W-1:0] ctrl_rd;
	logic [DATA_W-1:0] stat_rd;

	// ========================================================================
	// access decode
	// ========================================================================
	// misaligned, partial strobe, out of map, or STAT write
	assign acc_err = (paddr[1:0] != 2'b00) || (pstrb != '1) ||
		(paddr > ADDR_DATA) || (pwrite && (paddr == ADDR_STAT));

	always_comb
	begin
		if (!(psel && penable))
			op = OP_NONE;
		else if (acc_err)
			op = OP_ERROR;
		else if (pwrite)
			op = OP_WRITE;
		else
			op = OP_READ;
	end

	// never stalls
	assign pready  = 1'b1;
	assign pslverr = (op == OP_ERROR);

	// data port strobes, fifo itself drops push on full / pop on empty
	assign tx_push  = (op == OP_WRITE) && (paddr == ADDR_DATA);
	assign rx_pop   = (op == OP_READ) && (paddr == ADDR_DATA);
	assign tx_wdata = pwdata[FRAME_BITS-1:0];

	// ========================================================================
	// CTRL / BAUD
	// ========================================================================
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			enable     <= 1'b0;
			cpol       <= 1'b0;
			cpha       <= 1'b0;
			gap        <= '0;
			baud       <= '0;
			fifo_clear <= 1'b0;
		end
		else
		begin
			// one-cycle pulse
			fifo_clear <= 1'b0;
			if (op == OP_WRITE && paddr == ADDR_CTRL)
			begin
				if (pwdata[CTRL_SWR_BIT])
				begin
					// soft reset, config back to defaults
					enable     <= 1'b0;
					cpol       <= 1'b0;
					cpha       <= 1'b0;
					gap        <= '0;
					baud       <= '0;
					fifo_clear <= 1'b1;
				end
				else
				begin
					enable <= pwdata[CTRL_EN_BIT];
					cpol   <= pwdata[CTRL_CPOL_BIT];
					cpha   <= pwdata[CTRL_CPHA_BIT];
					gap    <= pwdata[CTRL_GAP_LSB +: GAP_W];
				end
			end
			if (op == OP_WRITE && paddr == ADDR_BAUD)
				baud <= pwdata[BAUD_W-1:0];
		end
	end

	// ========================================================================
	// read side
	// ========================================================================
	// swr bit and reserved bits read 0
	always_comb
	begin
		ctrl_rd                              = '0;
		ctrl_rd[CTRL_EN_BIT]                 = enable;
		ctrl_rd[CTRL_CPOL_BIT]               = cpol;
		ctrl_rd[CTRL_CPHA_BIT]               = cpha;
		ctrl_rd[CTRL_GAP_LSB +: GAP_W]       = gap;
	end

	always_comb
	begin
		stat_rd                                  = '0;
		stat_rd[STAT_TX_LVL_LSB +: FIFO_LVL_W]   = tx_level;
		stat_rd[STAT_RX_LVL_LSB +: FIFO_LVL_W]   = rx_level;
		stat_rd[STAT_TX_FULL_BIT]                = tx_full;
		stat_rd[STAT_TX_EMPTY_BIT]               = tx_empty;
		stat_rd[STAT_RX_FULL_BIT]                = rx_full;
		stat_rd[STAT_RX_EMPTY_BIT]               = rx_empty;
		stat_rd[STAT_BUSY_BIT]                   = busy;
	end

	// only valid reads return data
	always_comb
	begin
		prdata = '0;
		if (op == OP_READ)
		begin
			case (paddr)
				ADDR_CTRL: prdata = ctrl_rd;
				ADDR_BAUD: prdata = DATA_W'(baud);
				ADDR_STAT: prdata = stat_rd;
				// empty rx reads as zero
				ADDR_DATA: prdata = rx_empty ? '0 : DATA_W'(rx_rdata);
				default:   prdata = '0;
			endcase
		end
	end

endmodule

//--- source/spi_fifo.sv
/*
 * synchronous FIFO, first-word fall-through
 * shared by the TX and RX paths of the SPI master
 */

`timescale 1ns/1ps

module spi_fifo
	import spi_pkg::*;
(
	input  logic                  pclk,
	input  logic                  preset_n,
	input  logic                  clear,
	input  logic                  push,
	input  logic                  pop,
	input  logic [FRAME_BITS-1:0] wdata,
	output logic [FRAME_BITS-1:0] rdata,
	output logic [FIFO_LVL_W-1:0] level,
	output logic                  full,
	output logic                  empty
);

	// pointers carry one extra wrap bit
	logic [FIFO_PTR_W:0]   wr_ptr;
	logic [FIFO_PTR_W:0]   rd_ptr;
	logic [FRAME_BITS-1:0] mem [FIFO_DEPTH];
	logic                  wr_en;
	logic                  rd_en;

	// blocked strobes are simply dropped
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge pclk)
	begin
		if (wr_en)
			mem[wr_ptr[FIFO_PTR_W-1:0]] <= wdata;
	end

	// head entry always visible
	assign rdata = mem[rd_ptr[FIFO_PTR_W-1:0]];

	// flags from pointer difference
	assign level = wr_ptr - rd_ptr;
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]) &&
		(wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]);

endmodule

//--- source/spi_pkg.sv
/*
 * SPI master shared definitions
 * register map, field positions, FIFO sizing and the
 * state and access-kind enums used across the design
 */

package spi_pkg;

	// ========================================================================
	// bus and frame sizing
	// ========================================================================
	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 4;
	localparam int FRAME_BITS = 8;

	// fifo geometry, level needs one more bit than the pointer
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = 3;
	localparam int FIFO_LVL_W = 4;

	// ========================================================================
	// register map, byte offsets
	// ========================================================================
	localparam logic [ADDR_W-1:0] ADDR_CTRL = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_BAUD = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_STAT = 4'h8;
	localparam logic [ADDR_W-1:0] ADDR_DATA = 4'hC;

	// CTRL fields
	localparam int CTRL_EN_BIT   = 0;
	localparam int CTRL_CPOL_BIT = 1;
	localparam int CTRL_CPHA_BIT = 2;
	// self-clearing, flushes both fifos
	localparam int CTRL_SWR_BIT  = 3;
	localparam int CTRL_GAP_LSB  = 8;
	localparam int GAP_W         = 8;

	// BAUD field, half period is baud+1 pclk cycles
	localparam int BAUD_W = 8;

	// STAT fields
	localparam int STAT_TX_LVL_LSB   = 0;
	localparam int STAT_RX_LVL_LSB   = 4;
	localparam int STAT_TX_FULL_BIT  = 8;
	localparam int STAT_TX_EMPTY_BIT = 9;
	localparam int STAT_RX_FULL_BIT  = 10;
	localparam int STAT_RX_EMPTY_BIT = 11;
	localparam int STAT_BUSY_BIT     = 12;

	// sclk edge counter, two edges per bit
	localparam int                EDGE_W    = $clog2(2 * FRAME_BITS);
	localparam logic [EDGE_W-1:0] LAST_EDGE = EDGE_W'(2 * FRAME_BITS - 1);

	// ========================================================================
	// enums
	// ========================================================================
	// frame sequencer states
	typedef enum logic [1:0]
	{
		IDLE,
		LOAD,
		SHIFT,
		GAP
	} xfer_state_t;

	// decoded apb access kind
	typedef enum logic [1:0]
	{
		OP_NONE,
		OP_WRITE,
		OP_READ,
		OP_ERROR
	} apb_op_t;

endpackage

//--- source/spi_sclk_timer.sv
/*
 * SPI serial clock timer
 * divides pclk into 16 sclk half periods per frame, turns
 * the edges into sample/shift strobes, times the frame gap
 */

`timescale 1ns/1ps

module spi_sclk_timer
	import spi_pkg::*;
(
	input  logic              pclk,
	input  logic              preset_n,
	input  logic              cpol,
	input  logic              cpha,
	input  logic              frame_start,
	input  logic              gap_start,
	input  logic              fifo_clear,
	input  logic [BAUD_W-1:0] baud,
	input  logic [GAP_W-1:0]  gap,
	output logic              sclk,
	output logic              sample_strobe,
	output logic              shift_strobe,
	output logic              frame_done,
	output logic              gap_done
);

	logic              active;
	logic              tail;
	logic              gap_run;
	logic              edge_hit;
	logic              leading;
	logic [BAUD_W-1:0] div_cnt;
	logic [EDGE_W-1:0] edge_cnt;
	logic [GAP_W-1:0]  gap_cnt;

	// edge at end of each half period
	assign edge_hit = active && (div_cnt == baud);
	// odd-numbered edges leave the idle level
	assign leading  = !edge_cnt[0];

	// ========================================================================
	// half-period divider and edge counter
	// ========================================================================
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			active   <= 1'b0;
			tail     <= 1'b0;
			div_cnt  <= '0;
			edge_cnt <= '0;
			sclk     <= 1'b0;
		end
		else if (fifo_clear)
		begin
			active <= 1'b0;
			tail   <= 1'b0;
			sclk   <= cpol;
		end
		else
		begin
			// one cycle after the last edge
			tail <= edge_hit && (edge_cnt == LAST_EDGE);
			if (frame_start)
			begin
				active   <= 1'b1;
				div_cnt  <= '0;
				edge_cnt <= '0;
				sclk     <= cpol;
			end
			else if (edge_hit)
			begin
				div_cnt  <= '0;
				edge_cnt <= edge_cnt + 1'b1;
				sclk     <= ~sclk;
				if (edge_cnt == LAST_EDGE)
					active <= 1'b0;
			end
			else if (active)
				div_cnt <= div_cnt + 1'b1;
			else
				sclk <= cpol;
		end
	end

	// cpha 0: sample leading, shift trailing
	// cpha 1: sample trailing, shift later leading plus tail
	assign sample_strobe = edge_hit && (leading ^ cpha);
	assign shift_strobe  = cpha ?
		((edge_hit && leading && (edge_cnt != '0)) || tail) :
		(edge_hit && !leading);
	assign frame_done = tail;

	// ========================================================================
	// inter-frame gap, gap+1 cycles
	// ========================================================================
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			gap_run <= 1'b0;
			gap_cnt <= '0;
		end
		else if (fifo_clear)
			gap_run <= 1'b0;
		else if (gap_start)
		begin
			gap_run <= 1'b1;
			gap_cnt <= gap;
		end
		else if (gap_run)
		begin
			if (gap_cnt == '0)
				gap_run <= 1'b0;
			else
				gap_cnt <= gap_cnt - 1'b1;
		end
	end

	assign gap_done = gap_run && (gap_cnt == '0);

endmodule

//--- source/spi_shift_reg.sv
/*
 * SPI frame shift register
 * launches mosi from the MSB and collects miso at the LSB,
 * one held sample per shift
 */

`timescale 1ns/1ps

module spi_shift_reg
	import spi_pkg::*;
(
	input  logic                  pclk,
	input  logic                  preset_n,
	input  logic                  load,
	input  logic                  sample_strobe,
	input  logic                  shift_strobe,
	input  logic                  miso,
	input  logic [FRAME_BITS-1:0] tx_byte,
	output logic                  mosi,
	output logic [FRAME_BITS-1:0] rx_byte
);

	logic [FRAME_BITS-1:0] shreg;
	logic [FRAME_BITS-1:0] shreg_nxt;
	// miso bit waiting for its shift
	logic                  miso_q;

	// shifted view, sampled bit enters at LSB
	assign shreg_nxt = {shreg[FRAME_BITS-2:0], miso_q};

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			shreg  <= '0;
			miso_q <= 1'b0;
		end
		else
		begin
			// tx head byte, msb first
			if (load)
				shreg <= tx_byte;
			else if (shift_strobe)
				shreg <= shreg_nxt;
			if (sample_strobe)
				miso_q <= miso;
		end
	end

	assign mosi = shreg[FRAME_BITS-1];

	// final shift may land with the rx push,
	// so show the post-shift byte in that cycle
	assign rx_byte = shift_strobe ? shreg_nxt : shreg;

endmodule

//--- source/spi_top.sv
/*
 * APB SPI master top level
 * register block, TX/RX FIFOs, frame sequencer,
 * sclk timer and shift register
 */

`timescale 1ns/1ps

module spi_top
	import spi_pkg::*;
(
	input  logic                pclk,
	input  logic                preset_n,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [ADDR_W-1:0]   paddr,
	input  logic [DATA_W-1:0]   pwdata,
	input  logic [DATA_W/8-1:0] pstrb,
	output logic [DATA_W-1:0]   prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                sclk,
	output logic                mosi,
	output logic                ss_n,
	input  logic                miso
);

	// configuration
	logic                  enable;
	logic                  cpol;
	logic                  cpha;
	logic [GAP_W-1:0]      gap;
	logic [BAUD_W-1:0]     baud;
	logic                  fifo_clear;
	// tx path
	logic                  tx_push;
	logic                  tx_pop;
	logic [FRAME_BITS-1:0] tx_wdata;
	logic [FRAME_BITS-1:0] tx_byte;
	logic [FIFO_LVL_W-1:0] tx_level;
	logic                  tx_full;
	logic                  tx_empty;
	// rx path
	logic                  rx_push;
	logic                  rx_pop;
	logic [FRAME_BITS-1:0] rx_byte;
	logic [FRAME_BITS-1:0] rx_rdata;
	logic [FIFO_LVL_W-1:0] rx_level;
	logic                  rx_full;
	logic                  rx_empty;
	// sequencing
	logic                  busy;
	logic                  load;
	logic                  frame_start;
	logic                  frame_done;
	logic                  gap_start;
	logic                  gap_done;
	logic                  sample_strobe;
	logic                  shift_strobe;

	spi_apb_regs u_apb_regs
	(
		.pclk       (pclk),
		.preset_n   (preset_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pstrb      (pstrb),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.enable     (enable),
		.cpol       (cpol),
		.cpha       (cpha),
		.gap        (gap),
		.baud       (baud),
		.tx_push    (tx_push),
		.rx_pop     (rx_pop),
		.fifo_clear (fifo_clear),
		.tx_wdata   (tx_wdata),
		.tx_level   (tx_level),
		.rx_level   (rx_level),
		.tx_full    (tx_full),
		.tx_empty   (tx_empty),
		.rx_full    (rx_full),
		.rx_empty   (rx_empty),
		.busy       (busy),
		.rx_rdata   (rx_rdata)
	);

	// apb writes in, frames out
	spi_fifo u_tx_fifo
	(
		.pclk     (pclk),
		.preset_n (preset_n),
		.clear    (fifo_clear),
		.push     (tx_push),
		.pop      (tx_pop),
		.wdata    (tx_wdata),
		.rdata    (tx_byte),
		.level    (tx_level),
		.full     (tx_full),
		.empty    (tx_empty)
	);

	// received frames in, apb reads out
	spi_fifo u_rx_fifo
	(
		.pclk     (pclk),
		.preset_n (preset_n),
		.clear    (fifo_clear),
		.push     (rx_push),
		.pop      (rx_pop),
		.wdata    (rx_byte),
		.rdata    (rx_rdata),
		.level    (rx_level),
		.full     (rx_full),
		.empty    (rx_empty)
	);

	spi_xfer_fsm u_xfer_fsm
	(
		.pclk        (pclk),
		.preset_n    (preset_n),
		.enable      (enable),
		.tx_empty    (tx_empty),
		.frame_done  (frame_done),
		.gap_done    (gap_done),
		.fifo_clear  (fifo_clear),
		.tx_pop      (tx_pop),
		.rx_push     (rx_push),
		.load        (load),
		.frame_start (frame_start),
		.gap_start   (gap_start),
		.ss_n        (ss_n),
		.busy        (busy)
	);

	spi_sclk_timer u_sclk_timer
	(
		.pclk          (pclk),
		.preset_n      (preset_n),
		.cpol          (cpol),
		.cpha          (cpha),
		.frame_start   (frame_start),
		.gap_start     (gap_start),
		.fifo_clear    (fifo_clear),
		.baud          (baud),
		.gap           (gap),
		.sclk          (sclk),
		.sample_strobe (sample_strobe),
		.shift_strobe  (shift_strobe),
		.frame_done    (frame_done),
		.gap_done      (gap_done)
	);

	spi_shift_reg u_shift_reg
	(
		.pclk          (pclk),
		.preset_n      (preset_n),
		.load          (load),
		.sample_strobe (sample_strobe),
		.shift_strobe  (shift_strobe),
		.miso          (miso),
		.tx_byte       (tx_byte),
		.mosi          (mosi),
		.rx_byte       (rx_byte)
	);

endmodule

//--- source/spi_xfer_fsm.sv
/*
 * SPI frame sequencer
 * walks IDLE, LOAD, SHIFT, GAP; owns slave select,
 * the fifo pop/push strobes and the timer start pulses
 */

`timescale 1ns/1ps

module spi_xfer_fsm
	import spi_pkg::*;
(
	input  logic pclk,
	input  logic preset_n,
	input  logic enable,
	input  logic tx_empty,
	input  logic frame_done,
	input  logic gap_done,
	input  logic fifo_clear,
	output logic tx_pop,
	output logic rx_push,
	output logic load,
	output logic frame_start,
	output logic gap_start,
	output logic ss_n,
	output logic busy
);

	xfer_state_t state;
	xfer_state_t state_nxt;

	// ========================================================================
	// next state
	// ========================================================================
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (enable && !tx_empty)
					state_nxt = LOAD;
			end
			// single cycle, byte moves into shifter
			LOAD:
				state_nxt = SHIFT;
			SHIFT:
			begin
				if (frame_done)
					state_nxt = GAP;
			end
			// back to back frames only while enabled
			GAP:
			begin
				if (gap_done)
					state_nxt = (enable && !tx_empty) ? LOAD : IDLE;
			end
			default:
				state_nxt = IDLE;
		endcase
	end

	// ========================================================================
	// state and slave select
	// ========================================================================
	// ss_n registered from next state, glitch free on the pin
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			state <= IDLE;
			ss_n  <= 1'b1;
		end
		else if (fifo_clear)
		begin
			state <= IDLE;
			ss_n  <= 1'b1;
		end
		else
		begin
			state <= state_nxt;
			ss_n  <= !((state_nxt == LOAD) || (state_nxt == SHIFT));
		end
	end

	// strobes, all single cycle
	assign tx_pop      = (state == LOAD);
	assign load        = (state == LOAD);
	assign frame_start = (state == LOAD);
	assign rx_push     = (state == SHIFT) && frame_done;
	assign gap_start   = rx_push;

	assign busy = (state != IDLE);

endmodule

//--- testbench/tb_spi_top.sv
/*
 * testbench for the APB SPI master
 * drives register and data accesses over APB, models an SPI slave
 * in all four modes and checks frames, FIFO flags and error responses
 */

`timescale 1ns/1ps

module tb_spi_top;
	import spi_pkg::*;

	localparam int          DRIVE_DLY = 1;
	localparam logic [31:0] SEED      = 32'h3d8f;

	logic                pclk;
	logic                preset_n;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [ADDR_W-1:0]   paddr;
	logic [DATA_W-1:0]   pwdata;
	logic [DATA_W/8-1:0] pstrb;
	logic [DATA_W-1:0]   prdata;
	logic                pready;
	logic                pslverr;
	logic                sclk;
	logic                mosi;
	logic                ss_n;
	logic                miso;

	// frame bookkeeping
	int          tx_idx;
	int          rx_idx;
	int          seen_idx;
	int          sent;
	int          slave_frames;
	logic [31:0] rng;
	logic [7:0]  mosi_q[$];
	// mode the slave model follows
	logic        cur_cpol;
	logic        cur_cpha;
	logic [7:0]  cur_gap;
	logic        check_rest;
	// slave model state
	logic [7:0]  slave_byte;
	logic [7:0]  slave_unused;
	logic [7:0]  shift_in;
	logic        leading;
	int          bit_i;
	int          rise_cnt;

	spi_top dut
	(
		.pclk     (pclk),
		.preset_n (preset_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.pstrb    (pstrb),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.sclk     (sclk),
		.mosi     (mosi),
		.ss_n     (ss_n),
		.miso     (miso)
	);

	always #5 pclk = ~pclk;

	// ========================================================================
	// helpers
	// ========================================================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// bytes the slave should see and RX should hold for one frame index
	function automatic void spi_expect(input int idx, output logic [7:0] mosi_b,
		output logic [7:0] miso_b);
		logic [31:0] s;
		s = SEED;
		for (int i = 0; i <= idx; i++)
			s = xorshift(s);
		mosi_b = s[7:0];
		miso_b = s[23:16];
	endfunction

	function automatic logic [31:0] ctrl_word(input logic en, input logic pol,
		input logic pha, input logic [7:0] g);
		return {16'h0, g, 5'h0, pha, pol, en};
	endfunction

	// STAT word with flags following the fifo levels
	function automatic logic [31:0] stat_word(input int txl, input int rxl, input logic bsy);
		logic [31:0] w;
		w        = '0;
		w[3:0]   = txl[3:0];
		w[7:4]   = rxl[3:0];
		w[8]     = (txl == 8);
		w[9]     = (txl == 0);
		w[10]    = (rxl == 8);
		w[11]    = (rxl == 0);
		w[12]    = bsy;
		return w;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0d ns: %s, got 0x%0h expected 0x%0h",
				$time, what, got, exp));
	endtask

	// ========================================================================
	// APB master
	// ========================================================================
	task automatic apb_xfer(input apb_op_t op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [3:0] strb,
		output logic [DATA_W-1:0] rdata, output logic err);
		// setup phase
		@(posedge pclk);
		#DRIVE_DLY;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = (op == OP_WRITE);
		paddr   = addr;
		pwdata  = wdata;
		pstrb   = strb;
		// access phase
		@(posedge pclk);
		#DRIVE_DLY;
		penable = 1'b1;
		// outputs settled mid cycle
		@(negedge pclk);
		rdata = prdata;
		err   = pslverr;
		check_eq(pready, 1'b1, "pready low");
		@(posedge pclk);
		#DRIVE_DLY;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rd;
		logic              err;
		apb_xfer(OP_WRITE, addr, data, 4'hF, rd, err);
		check_eq(err, 1'b0, $sformatf("pslverr on write to 0x%0h", addr));
	endtask

	task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		logic err;
		apb_xfer(OP_READ, addr, '0, 4'hF, data, err);
		check_eq(err, 1'b0, $sformatf("pslverr on read of 0x%0h", addr));
	endtask

	// expects pslverr on a rejected access
	task automatic bad_access(input apb_op_t op, input logic [ADDR_W-1:0] addr,
		input logic [3:0] strb);
		logic [DATA_W-1:0] rd;
		logic              err;
		apb_xfer(op, addr, 32'h0000_ff07, strb, rd, err);
		check_eq(err, 1'b1, $sformatf("no pslverr at 0x%0h strb 0x%0h", addr, strb));
		check_eq(rd, 32'h0, "prdata on error");
	endtask

	// ========================================================================
	// test sequences
	// ========================================================================
	task automatic set_mode(input logic pol, input logic pha, input logic [7:0] b,
		input logic [7:0] g);
		// sclk may follow cpol while reconfiguring
		check_rest = 1'b0;
		cur_cpol   = pol;
		cur_cpha   = pha;
		cur_gap    = g;
		reg_write(ADDR_CTRL, ctrl_word(1'b0, pol, pha, g));
		reg_write(ADDR_BAUD, {24'h0, b});
		check_rest = 1'b1;
	endtask

	task automatic queue_bytes(input int n);
		logic [7:0] m;
		logic [7:0] s;
		for (int i = 0; i < n; i++)
		begin
			spi_expect(tx_idx, m, s);
			reg_write(ADDR_DATA, {24'h0, m});
			tx_idx++;
			sent++;
		end
	endtask

	// polls STAT until idle with TX drained
	task automatic wait_idle(input int max_polls);
		logic [DATA_W-1:0] st;
		int                n;
		n = 0;
		reg_read(ADDR_STAT, st);
		while ((st[12] || !st[9]) && n < max_polls)
		begin
			reg_read(ADDR_STAT, st);
			n++;
		end
		if (n >= max_polls)
			abort_run("timeout: transfers did not finish, DUT stayed busy");
	endtask

	task automatic check_frames(input int n);
		logic [7:0] m;
		logic [7:0] s;
		check_eq(mosi_q.size(), n, "frames seen by slave");
		for (int i = 0; i < n; i++)
		begin
			spi_expect(seen_idx, m, s);
			check_eq(mosi_q.pop_front(), m, $sformatf("mosi byte of frame %0d", seen_idx));
			seen_idx++;
		end
		check_eq(slave_frames, sent, "ss_n low periods vs bytes written");
	endtask

	task automatic drain_rx(input int n);
		logic [DATA_W-1:0] rd;
		logic [7:0]        m;
		logic [7:0]        s;
		for (int i = 0; i < n; i++)
		begin
			spi_expect(rx_idx, m, s);
			reg_read(ADDR_DATA, rd);
			check_eq(rd, {24'h0, s}, $sformatf("rx byte of frame %0d", rx_idx));
			rx_idx++;
		end
	endtask

	// ========================================================================
	// SPI slave model
	// ========================================================================
	always
	begin
		@(negedge ss_n);
		spi_expect(slave_frames, slave_unused, slave_byte);
		check_eq(sclk, cur_cpol, "sclk level at ss_n fall");
		shift_in = '0;
		bit_i    = 0;
		rise_cnt = 0;
		// cpha 0 needs the msb before the first edge
		if (!cur_cpha)
		begin
			#DRIVE_DLY;
			miso  = slave_byte[7];
			bit_i = 1;
		end
		while (ss_n === 1'b0)
		begin
			@(sclk or ss_n);
			if (ss_n === 1'b0)
			begin
				if (sclk)
					rise_cnt++;
				leading = (sclk != cur_cpol);
				if (leading != cur_cpha)
					shift_in = {shift_in[6:0], mosi};
				else if (bit_i < 8)
				begin
					#DRIVE_DLY;
					miso = slave_byte[7-bit_i];
					bit_i++;
				end
			end
		end
		mosi_q.push_back(shift_in);
		slave_frames++;
		check_eq(rise_cnt, 8, "sclk rising edges in one frame");
	end

	// idle sclk must not move between frames
	always @(sclk)
	begin
		if (check_rest && ss_n === 1'b1)
			check_eq(sclk, cur_cpol, "sclk left rest level while ss_n high");
	end

	// ========================================================================
	// main sequence
	// ========================================================================
	initial
	begin
		logic [DATA_W-1:0] rd;

		pclk       = 1'b0;
		preset_n   = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		pstrb      = '0;
		miso       = 1'b0;
		tx_idx     = 0;
		rx_idx     = 0;
		seen_idx   = 0;
		sent       = 0;
		slave_frames = 0;
		rng        = SEED;
		cur_cpol   = 1'b0;
		cur_cpha   = 1'b0;
		cur_gap    = '0;
		check_rest = 1'b0;
		repeat (16) @(posedge pclk);
		#DRIVE_DLY;
		preset_n = 1'b1;

		// reset values
		check_eq(ss_n, 1'b1, "ss_n after reset");
		check_eq(sclk, 1'b0, "sclk after reset");
		reg_read(ADDR_CTRL, rd);
		check_eq(rd, 32'h0, "CTRL after reset");
		reg_read(ADDR_BAUD, rd);
		check_eq(rd, 32'h0, "BAUD after reset");
		reg_read(ADDR_STAT, rd);
		check_eq(rd, stat_word(0, 0, 1'b0), "STAT after reset");

		// reserved bits masked on readback
		reg_write(ADDR_CTRL, 32'hffff_fff7);
		reg_read(ADDR_CTRL, rd);
		check_eq(rd, 32'h0000_ff07, "CTRL readback");
		reg_write(ADDR_BAUD, 32'hffff_ffa5);
		reg_read(ADDR_BAUD, rd);
		check_eq(rd, 32'h0000_00a5, "BAUD readback");
		// swr reads back 0 and clears config
		reg_write(ADDR_CTRL, 32'hffff_ffff);
		reg_read(ADDR_CTRL, rd);
		check_eq(rd, 32'h0, "CTRL after soft reset write");

		// all four modes with random baud and gap
		for (int mode = 0; mode < 4; mode++)
		begin
			rng = xorshift(rng);
			set_mode(mode[1], mode[0], {5'h0, rng[2:0]}, {4'h0, rng[11:8]});
			queue_bytes(5);
			reg_write(ADDR_CTRL, ctrl_word(1'b1, cur_cpol, cur_cpha, cur_gap));
			wait_idle(2000);
			check_frames(5);
			reg_read(ADDR_STAT, rd);
			check_eq(rd, stat_word(0, 5, 1'b0), "STAT after mode run");
			drain_rx(5);
		end

		// ninth byte is dropped while TX is full
		set_mode(1'b0, 1'b0, 8'h02, 8'h01);
		queue_bytes(8);
		reg_write(ADDR_DATA, 32'h0000_005a);
		reg_read(ADDR_STAT, rd);
		check_eq(rd, stat_word(8, 0, 1'b0), "STAT with TX full");
		reg_write(ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 8'h01));
		wait_idle(2000);
		check_frames(8);
		reg_read(ADDR_STAT, rd);
		check_eq(rd, stat_word(0, 8, 1'b0), "STAT with RX full");
		drain_rx(6);

		// error responses change nothing
		set_mode(1'b0, 1'b1, 8'h3c, 8'h21);
		bad_access(OP_WRITE, 4'h1, 4'hF);
		bad_access(OP_WRITE, ADDR_CTRL, 4'b0111);
		bad_access(OP_WRITE, ADDR_DATA, 4'b0001);
		bad_access(OP_READ, ADDR_DATA, 4'b0011);
		bad_access(OP_WRITE, ADDR_STAT, 4'hF);
		bad_access(OP_WRITE, 4'hF, 4'hF);
		bad_access(OP_WRITE, 4'hD, 4'hF);
		bad_access(OP_READ, 4'hE, 4'hF);
		reg_read(ADDR_CTRL, rd);
		check_eq(rd, ctrl_word(1'b0, 1'b0, 1'b1, 8'h21), "CTRL after bad accesses");
		reg_read(ADDR_BAUD, rd);
		check_eq(rd, 32'h0000_003c, "BAUD after bad accesses");
		reg_read(ADDR_STAT, rd);
		check_eq(rd, stat_word(0, 2, 1'b0), "STAT after bad accesses");

		// soft reset flushes both fifos
		for (int i = 0; i < 3; i++)
			reg_write(ADDR_DATA, 32'h0000_00c3);
		reg_read(ADDR_STAT, rd);
		check_eq(rd, stat_word(3, 2, 1'b0), "STAT before soft reset");
		reg_write(ADDR_CTRL, 32'h0000_0008);
		reg_read(ADDR_STAT, rd);
		check_eq(rd, stat_word(0, 0, 1'b0), "STAT after soft reset");
		reg_read(ADDR_CTRL, rd);
		check_eq(rd, 32'h0, "CTRL after soft reset");
		reg_read(ADDR_BAUD, rd);
		check_eq(rd, 32'h0, "BAUD after soft reset");
		reg_read(ADDR_DATA, rd);
		check_eq(rd, 32'h0, "DATA read of empty RX");
		check_eq(ss_n, 1'b1, "ss_n after soft reset");
		check_eq(slave_frames, sent, "total frames vs bytes sent");

		$display("Everything OK");
		$finish;
	end

endmodule
